// File: include/de_config.svh
`ifndef DE_CONFIG_SVH
`define DE_CONFIG_SVH

// datapath and register file sizing
`define DE_XLEN       32
`define DE_REG_COUNT  32
`define DE_REG_BITS   5

////////////////////////////////////////////////////////////////////////////
// major opcodes
////////////////////////////////////////////////////////////////////////////
`define DE_OPC_OP      7'b0110011  // register-register alu and mul
`define DE_OPC_OP_IMM  7'b0010011
`define DE_OPC_LUI     7'b0110111
`define DE_OPC_AUIPC   7'b0010111
`define DE_OPC_LOAD    7'b0000011
`define DE_OPC_STORE   7'b0100011
`define DE_OPC_JAL     7'b1101111
`define DE_OPC_JALR    7'b1100111
`define DE_OPC_BRANCH  7'b1100011
`define DE_OPC_SYSTEM  7'b1110011  // csr access

// funct3 for alu ops, shared by the register and immediate forms
`define DE_F3_ADD   3'b000
`define DE_F3_SLL   3'b001
`define DE_F3_SLT   3'b010
`define DE_F3_SLTU  3'b011
`define DE_F3_XOR   3'b100
`define DE_F3_SR    3'b101  // srl and sra, split by funct7
`define DE_F3_OR    3'b110
`define DE_F3_AND   3'b111

// funct3 for branches
`define DE_F3_BEQ   3'b000
`define DE_F3_BNE   3'b001
`define DE_F3_BLT   3'b100
`define DE_F3_BGE   3'b101
`define DE_F3_BLTU  3'b110
`define DE_F3_BGEU  3'b111

`define DE_F3_LW    3'b010
`define DE_F3_SW    3'b010
`define DE_F3_JALR  3'b000
`define DE_F3_CSRW  3'b001
`define DE_F3_CSRR  3'b010

`define DE_F7_BASE    7'b0000000
`define DE_F7_ALT     7'b0100000  // sub, sra, srai
`define DE_F7_MULDIV  7'b0000001

`endif

// File: source/de_pkg.sv
`default_nettype none

`include "de_config.svh"

package de_pkg;

  typedef logic [`DE_XLEN-1:0]     word_t;
  typedef logic [`DE_REG_BITS-1:0] regno_t;

  // internal op codes, zero encoding doubles as the bubble value
  typedef enum logic [5:0] {
    op_invalid = 6'd0,
    op_add, op_sub, op_and, op_or, op_xor,
    op_slt, op_sltu, op_sra, op_srl, op_sll,
    op_mul,
    op_addi, op_andi, op_ori, op_xori, op_slti,
    op_sltiu, op_srai, op_srli, op_slli,
    op_lui, op_auipc,
    op_lw, op_sw,
    op_jal, op_jalr,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_csrr, op_csrw
  } op_e;

  // format class, decides which source registers are read
  typedef enum logic [2:0] {
    fmt_none, fmt_r, fmt_i, fmt_s, fmt_u
  } fmt_e;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_e;

  ////////////////////////////////////////////////////////////////////////////
  // instruction word layouts
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    regno_t     rs2;
    regno_t     rs1;
    logic [2:0] funct3;
    regno_t     rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    regno_t      rs1;
    logic [2:0]  funct3;
    regno_t      rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // b-type immediate bits live in the same slots
  typedef struct packed {
    logic [6:0] imm_hi;
    regno_t     rs2;
    regno_t     rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // j-type immediate is a permutation of imm_31_12
  typedef struct packed {
    logic [19:0] imm_31_12;
    regno_t      rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } inst_u;

endpackage

`default_nettype wire

// File: source/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

// one decoded instruction, purely combinational from the fetched word
interface decode_if;
  import de_pkg::*;

  op_e    op;
  regno_t rs1;
  regno_t rs2;
  regno_t rd;
  logic   use_rs1;
  logic   use_rs2;
  word_t  imm;
  logic   is_br;
  logic   is_jmp;
  logic   rd_mem;
  logic   wr_mem;
  logic   wr_reg;

  modport producer (
    output op, rs1, rs2, rd, use_rs1, use_rs2, imm,
           is_br, is_jmp, rd_mem, wr_mem, wr_reg
  );

  modport consumer (
    input op, rs1, rs2, rd, use_rs1, use_rs2, imm,
          is_br, is_jmp, rd_mem, wr_mem, wr_reg
  );

endinterface

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic           clk,
  input  logic           reset,

  // from fetch
  input  logic           fe_valid,
  input  de_pkg::word_t  fe_inst,
  input  de_pkg::word_t  fe_pc,
  input  de_pkg::word_t  fe_pcplus,
  input  de_pkg::word_t  fe_pcnext,
  input  logic           br_mispred,

  // writeback port
  input  logic           wb_wr_reg,
  input  de_pkg::regno_t wb_regno,
  input  de_pkg::word_t  wb_regval,

  output logic           stall,

  // pipeline latch
  output logic           de_valid,
  output de_pkg::word_t  de_pc,
  output de_pkg::word_t  de_pcplus,
  output de_pkg::word_t  de_pcnext,
  output de_pkg::op_e    de_op,
  output de_pkg::word_t  de_rs1_val,
  output de_pkg::word_t  de_rs2_val,
  output de_pkg::word_t  de_imm,
  output logic           de_is_br,
  output logic           de_is_jmp,
  output logic           de_rd_mem,
  output logic           de_wr_mem,
  output logic           de_wr_reg,
  output de_pkg::regno_t de_rd
);
  import de_pkg::*;

  decode_if dec_bus ();

  word_t rs1_val;
  word_t rs2_val;

  inst_decoder u_decoder (
    .inst (inst_u'(fe_inst)),
    .dec  (dec_bus)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .reset     (reset),
    .rs1       (dec_bus.rs1),
    .rs2       (dec_bus.rs2),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .wb_wr_reg (wb_wr_reg),
    .wb_regno  (wb_regno),
    .wb_regval (wb_regval)
  );

  hazard_scoreboard u_scoreboard (
    .clk        (clk),
    .reset      (reset),
    .dec        (dec_bus),
    .fe_valid   (fe_valid),
    .br_mispred (br_mispred),
    .wb_wr_reg  (wb_wr_reg),
    .wb_regno   (wb_regno),
    .stall      (stall)
  );

  ////////////////////////////////////////////////////////////////////////////
  // output latch, a stall loads a bubble
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de_valid   <= 1'b0;
      de_pc      <= '0;
      de_pcplus  <= '0;
      de_pcnext  <= '0;
      de_op      <= op_invalid;  // zero encoding
      de_rs1_val <= '0;
      de_rs2_val <= '0;
      de_imm     <= '0;
      de_is_br   <= 1'b0;
      de_is_jmp  <= 1'b0;
      de_rd_mem  <= 1'b0;
      de_wr_mem  <= 1'b0;
      de_wr_reg  <= 1'b0;
      de_rd      <= '0;
    end else if (stall) begin
      de_valid   <= 1'b0;
      de_pc      <= '0;
      de_pcplus  <= '0;
      de_pcnext  <= '0;
      de_op      <= op_invalid;
      de_rs1_val <= '0;
      de_rs2_val <= '0;
      de_imm     <= '0;
      de_is_br   <= 1'b0;
      de_is_jmp  <= 1'b0;
      de_rd_mem  <= 1'b0;
      de_wr_mem  <= 1'b0;
      de_wr_reg  <= 1'b0;
      de_rd      <= '0;
    end else begin
      de_valid   <= fe_valid;
      de_pc      <= fe_pc;
      de_pcplus  <= fe_pcplus;
      de_pcnext  <= fe_pcnext;
      de_op      <= dec_bus.op;
      de_rs1_val <= rs1_val;
      de_rs2_val <= rs2_val;
      de_imm     <= dec_bus.imm;
      de_is_br   <= dec_bus.is_br;
      de_is_jmp  <= dec_bus.is_jmp;
      de_rd_mem  <= dec_bus.rd_mem;
      de_wr_mem  <= dec_bus.wr_mem;
      de_wr_reg  <= dec_bus.wr_reg;
      de_rd      <= dec_bus.rd;
    end
  end

  // a stalled cycle must never leak a valid instruction downstream
  a_stall_bubble: assert property (@(posedge clk) disable iff (reset)
    stall |=> !de_valid);

endmodule

`default_nettype wire

// File: source/hazard_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "de_config.svh"

module hazard_scoreboard (
  input  logic           clk,
  input  logic           reset,
  decode_if.consumer     dec,
  input  logic           fe_valid,
  input  logic           br_mispred,
  input  logic           wb_wr_reg,
  input  de_pkg::regno_t wb_regno,
  output logic           stall
);
  import de_pkg::*;

  logic [`DE_REG_COUNT-1:0] busy;
  logic [`DE_REG_COUNT-1:0] busy_nxt;
  logic raw_hazard;
  logic accept_wr;

  // read-after-write on any source still in flight
  assign raw_hazard = fe_valid &&
                      ((dec.use_rs1 && busy[dec.rs1]) ||
                       (dec.use_rs2 && busy[dec.rs2]));

  assign stall     = br_mispred || raw_hazard;
  assign accept_wr = fe_valid && !stall && dec.wr_reg;

  always_comb begin
    busy_nxt = busy;
    if (wb_wr_reg) begin
      busy_nxt[wb_regno] = 1'b0;
    end
    // set after clear, the newer instruction wins
    if (accept_wr) begin
      busy_nxt[dec.rd] = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= busy_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  // writeback must match an instruction this stage issued earlier
  a_wb_was_busy: assert property (@(posedge clk) disable iff (reset)
    (wb_wr_reg && (wb_regno != '0)) |-> busy[wb_regno]);

  a_x0_never_busy: assert property (@(posedge clk) disable iff (reset)
    !busy[0]);

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "de_config.svh"

module inst_decoder (
  input  de_pkg::inst_u inst,
  decode_if.producer    dec
);
  import de_pkg::*;

  op_e   op_dec;
  fmt_e  fmt;
  imm_e  imm_kind;
  logic  writes;    // op class writes rd
  word_t imm;

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;

  assign opcode = inst.r.opcode;
  assign f3     = inst.r.funct3;
  assign f7     = inst.r.funct7;

  ////////////////////////////////////////////////////////////////////////////
  // op decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    op_dec = op_invalid;
    case (opcode)
      `DE_OPC_OP: begin
        case ({f7, f3})
          {`DE_F7_BASE, `DE_F3_ADD}:    op_dec = op_add;
          {`DE_F7_ALT, `DE_F3_ADD}:     op_dec = op_sub;
          {`DE_F7_BASE, `DE_F3_AND}:    op_dec = op_and;
          {`DE_F7_BASE, `DE_F3_OR}:     op_dec = op_or;
          {`DE_F7_BASE, `DE_F3_XOR}:    op_dec = op_xor;
          {`DE_F7_BASE, `DE_F3_SLT}:    op_dec = op_slt;
          {`DE_F7_BASE, `DE_F3_SLTU}:   op_dec = op_sltu;
          {`DE_F7_ALT, `DE_F3_SR}:      op_dec = op_sra;
          {`DE_F7_BASE, `DE_F3_SR}:     op_dec = op_srl;
          {`DE_F7_BASE, `DE_F3_SLL}:    op_dec = op_sll;
          {`DE_F7_MULDIV, `DE_F3_ADD}:  op_dec = op_mul;
          default:                      op_dec = op_invalid;
        endcase
      end
      `DE_OPC_OP_IMM: begin
        case (f3)
          `DE_F3_ADD:  op_dec = op_addi;
          `DE_F3_AND:  op_dec = op_andi;
          `DE_F3_OR:   op_dec = op_ori;
          `DE_F3_XOR:  op_dec = op_xori;
          `DE_F3_SLT:  op_dec = op_slti;
          `DE_F3_SLTU: op_dec = op_sltiu;
          // shifts also need a legal funct7
          `DE_F3_SLL:  op_dec = (f7 == `DE_F7_BASE) ? op_slli : op_invalid;
          `DE_F3_SR: begin
            if (f7 == `DE_F7_ALT)
              op_dec = op_srai;
            else if (f7 == `DE_F7_BASE)
              op_dec = op_srli;
          end
          default:     op_dec = op_invalid;
        endcase
      end
      `DE_OPC_LUI:   op_dec = op_lui;
      `DE_OPC_AUIPC: op_dec = op_auipc;
      `DE_OPC_LOAD:  op_dec = (f3 == `DE_F3_LW) ? op_lw : op_invalid;
      `DE_OPC_STORE: op_dec = (f3 == `DE_F3_SW) ? op_sw : op_invalid;
      `DE_OPC_JAL:   op_dec = op_jal;
      `DE_OPC_JALR:  op_dec = (f3 == `DE_F3_JALR) ? op_jalr : op_invalid;
      `DE_OPC_BRANCH: begin
        case (f3)
          `DE_F3_BEQ:  op_dec = op_beq;
          `DE_F3_BNE:  op_dec = op_bne;
          `DE_F3_BLT:  op_dec = op_blt;
          `DE_F3_BGE:  op_dec = op_bge;
          `DE_F3_BLTU: op_dec = op_bltu;
          `DE_F3_BGEU: op_dec = op_bgeu;
          default:     op_dec = op_invalid;
        endcase
      end
      `DE_OPC_SYSTEM: begin
        if (f3 == `DE_F3_CSRR)
          op_dec = op_csrr;
        else if (f3 == `DE_F3_CSRW)
          op_dec = op_csrw;
      end
      default: op_dec = op_invalid;
    endcase
  end

  // format class, immediate kind and rd write, all keyed on op
  always_comb begin
    fmt      = fmt_none;
    imm_kind = imm_none;
    writes   = 1'b0;
    case (op_dec)
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu,
      op_sra, op_srl, op_sll, op_mul: begin
        fmt    = fmt_r;
        writes = 1'b1;
      end
      op_addi, op_andi, op_ori, op_xori, op_slti, op_sltiu,
      op_srai, op_srli, op_slli, op_lw, op_jalr, op_csrr: begin
        fmt      = fmt_i;
        imm_kind = imm_i;
        writes   = 1'b1;
      end
      op_csrw: begin
        fmt      = fmt_i;  // reads rs1, no rd write
        imm_kind = imm_i;
      end
      op_lui, op_auipc: begin
        fmt      = fmt_u;
        imm_kind = imm_u;
        writes   = 1'b1;
      end
      op_sw: begin
        fmt      = fmt_s;
        imm_kind = imm_s;
      end
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
        fmt      = fmt_s;
        imm_kind = imm_b;
      end
      op_jal: begin
        fmt      = fmt_u;
        imm_kind = imm_j;
        writes   = 1'b1;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // sign-extended immediate
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (imm_kind)
      imm_i: imm = {{(`DE_XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
      imm_s: imm = {{(`DE_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      imm_b: imm = {{(`DE_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_lo[0],
                    inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
      imm_u: imm = {inst.u.imm_31_12, 12'b0};
      imm_j: imm = {{(`DE_XLEN-20){inst.u.imm_31_12[19]}}, inst.u.imm_31_12[7:0],
                    inst.u.imm_31_12[8], inst.u.imm_31_12[18:9], 1'b0};
      default: imm = '0;
    endcase
  end

  assign dec.op      = op_dec;
  assign dec.rs1     = inst.r.rs1;
  assign dec.rs2     = inst.r.rs2;
  assign dec.rd      = inst.r.rd;
  assign dec.use_rs1 = (fmt == fmt_r) || (fmt == fmt_i) || (fmt == fmt_s);
  assign dec.use_rs2 = (fmt == fmt_r) || (fmt == fmt_s);
  assign dec.imm     = imm;
  assign dec.is_br   = (imm_kind == imm_b);
  assign dec.is_jmp  = (op_dec == op_jal) || (op_dec == op_jalr);
  assign dec.rd_mem  = (op_dec == op_lw);
  assign dec.wr_mem  = (op_dec == op_sw);
  assign dec.wr_reg  = writes && (inst.r.rd != '0);  // x0 is never a target

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "de_config.svh"

module reg_file (
  input  logic           clk,
  input  logic           reset,
  input  de_pkg::regno_t rs1,
  input  de_pkg::regno_t rs2,
  output de_pkg::word_t  rs1_val,
  output de_pkg::word_t  rs2_val,
  input  logic           wb_wr_reg,
  input  de_pkg::regno_t wb_regno,
  input  de_pkg::word_t  wb_regval
);
  import de_pkg::*;

  word_t regs [`DE_REG_COUNT];
  logic  wb_live;

  // writes to x0 are dropped here
  assign wb_live = wb_wr_reg && (wb_regno != '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int k = 0; k < `DE_REG_COUNT; k++) begin
        regs[k] <= '0;
      end
    end else if (wb_live) begin
      regs[wb_regno] <= wb_regval;
    end
  end

  // write-through, a read in the writeback cycle sees the new value
  assign rs1_val = (wb_live && (wb_regno == rs1)) ? wb_regval : regs[rs1];
  assign rs2_val = (wb_live && (wb_regno == rs2)) ? wb_regval : regs[rs2];

endmodule

`default_nettype wire

// File: src.f
+incdir+include
source/de_pkg.sv
source/decode_if.sv
source/inst_decoder.sv
source/reg_file.sv
source/hazard_scoreboard.sv
source/decode_stage.sv
verif/tb_clock.sv
verif/decode_stage_tb.sv

// File: verif/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;
  import de_pkg::*;

  localparam int NUM_TESTS   = 5;
  localparam int WATCHDOG_NS = NUM_TESTS * 200 * 20;

  // major opcodes from the rv32i spec
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_IMM    = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;

  logic   clk;
  logic   reset;
  logic   fe_valid;
  word_t  fe_inst;
  word_t  fe_pc;
  word_t  fe_pcplus;
  word_t  fe_pcnext;
  logic   br_mispred;
  logic   wb_wr_reg;
  regno_t wb_regno;
  word_t  wb_regval;
  logic   stall;
  logic   de_valid;
  word_t  de_pc;
  word_t  de_pcplus;
  word_t  de_pcnext;
  op_e    de_op;
  word_t  de_rs1_val;
  word_t  de_rs2_val;
  word_t  de_imm;
  logic   de_is_br;
  logic   de_is_jmp;
  logic   de_rd_mem;
  logic   de_wr_mem;
  logic   de_wr_reg;
  regno_t de_rd;

  logic   stall_seen;   // stall sampled mid-cycle, before the rising edge
  word_t  sent_pc;
  word_t  sent_pcnext;
  word_t  model [32];   // expected register file contents
  int     errors;

  tb_clock u_clock (.clk(clk));

  decode_stage decode_stage_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic fail_run();
    errors++;
    $display("Finished with errors");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_op(input string name, input op_e exp, input op_e act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_regno(input string name, input regno_t exp, input regno_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model, rv32i encodings and immediate rules
  ////////////////////////////////////////////////////////////////////////////
  function automatic word_t sext(input word_t v, input int bits);
    word_t sh;
    sh = v << (32 - bits);
    return word_t'($signed(sh) >>> (32 - bits));
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input regno_t rs2, input regno_t rs1,
                                  input logic [2:0] f3, input regno_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input regno_t rs1,
                                  input logic [2:0] f3, input regno_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input regno_t rs2, input regno_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  // beq, imm[0] is implied zero
  function automatic word_t enc_b(input logic [12:0] imm, input regno_t rs2, input regno_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input regno_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic regno_t nz_reg();
    return regno_t'(1 + ($urandom % 31));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers, each step starts and ends on a falling edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic step(input logic valid, input word_t inst, input logic wb_en,
                      input regno_t wb_r, input word_t wb_v);
    fe_valid    = valid;
    fe_inst     = inst;
    fe_pc       = $urandom & 32'hffff_fffc;
    fe_pcplus   = fe_pc + 4;
    fe_pcnext   = $urandom & 32'hffff_fffc;
    wb_wr_reg   = wb_en;
    wb_regno    = wb_r;
    wb_regval   = wb_v;
    sent_pc     = fe_pc;
    sent_pcnext = fe_pcnext;
    #2;
    stall_seen = stall;
    @(negedge clk);
  endtask

  // writeback of the model value frees the busy bit
  task automatic retire(input regno_t rd);
    step(1'b0, '0, 1'b1, rd, model[rd]);
  endtask

  // ctl is {is_br, is_jmp, rd_mem, wr_mem, wr_reg}
  task automatic issue_expect(input word_t inst, input op_e op, input word_t imm,
                              input logic [4:0] ctl, input regno_t rd);
    step(1'b1, inst, 1'b0, '0, '0);
    check_bit("stall", 1'b0, stall_seen);
    check_bit("de_valid", 1'b1, de_valid);
    check_word("de_pc", sent_pc, de_pc);
    check_word("de_pcplus", sent_pc + 4, de_pcplus);
    check_word("de_pcnext", sent_pcnext, de_pcnext);
    check_op("de_op", op, de_op);
    check_word("de_imm", imm, de_imm);
    check_word("de_rs1_val", model[inst[19:15]], de_rs1_val);
    check_word("de_rs2_val", model[inst[24:20]], de_rs2_val);
    check_bit("de_is_br", ctl[4], de_is_br);
    check_bit("de_is_jmp", ctl[3], de_is_jmp);
    check_bit("de_rd_mem", ctl[2], de_rd_mem);
    check_bit("de_wr_mem", ctl[1], de_wr_mem);
    check_bit("de_wr_reg", ctl[0], de_wr_reg);
    check_regno("de_rd", rd, de_rd);
    if (ctl[0])
      retire(rd);
  endtask

  task automatic run_alu_op(input op_e op, input logic is_r, input logic [6:0] f7,
                            input logic [2:0] f3);
    regno_t      rd;
    regno_t      rs1;
    regno_t      rs2;
    logic [11:0] imm12;
    for (int rep = 0; rep < 2; rep++) begin
      rd    = (rep == 0) ? nz_reg() : '0;
      rs1   = regno_t'($urandom);
      rs2   = regno_t'($urandom);
      imm12 = 12'($urandom);
      if (is_r)
        issue_expect(enc_r(f7, rs2, rs1, f3, rd, OPC_OP), op, '0, {4'b0, rd != 0}, rd);
      else if (f3 == 3'b001 || f3 == 3'b101)  // shamt sits in the rs2 slot
        issue_expect(enc_r(f7, rs2, rs1, f3, rd, OPC_IMM), op, sext({f7, rs2}, 12),
                     {4'b0, rd != 0}, rd);
      else
        issue_expect(enc_i(imm12, rs1, f3, rd, OPC_IMM), op, sext(imm12, 12),
                     {4'b0, rd != 0}, rd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_alu_decode();
    run_alu_op(op_add, 1, 7'h00, 3'd0);
    run_alu_op(op_sub, 1, 7'h20, 3'd0);
    run_alu_op(op_sll, 1, 7'h00, 3'd1);
    run_alu_op(op_slt, 1, 7'h00, 3'd2);
    run_alu_op(op_sltu, 1, 7'h00, 3'd3);
    run_alu_op(op_xor, 1, 7'h00, 3'd4);
    run_alu_op(op_srl, 1, 7'h00, 3'd5);
    run_alu_op(op_sra, 1, 7'h20, 3'd5);
    run_alu_op(op_or, 1, 7'h00, 3'd6);
    run_alu_op(op_and, 1, 7'h00, 3'd7);
    run_alu_op(op_mul, 1, 7'h01, 3'd0);
    run_alu_op(op_addi, 0, 7'h00, 3'd0);
    run_alu_op(op_slli, 0, 7'h00, 3'd1);
    run_alu_op(op_slti, 0, 7'h00, 3'd2);
    run_alu_op(op_sltiu, 0, 7'h00, 3'd3);
    run_alu_op(op_xori, 0, 7'h00, 3'd4);
    run_alu_op(op_srli, 0, 7'h00, 3'd5);
    run_alu_op(op_srai, 0, 7'h20, 3'd5);
    run_alu_op(op_ori, 0, 7'h00, 3'd6);
    run_alu_op(op_andi, 0, 7'h00, 3'd7);
  endtask

  task automatic test_immediates();
    regno_t      rd;
    regno_t      rs1;
    regno_t      rs2;
    logic [11:0] i12;
    logic [12:0] b13;
    logic [19:0] u20;
    logic [20:0] j21;
    for (int rep = 0; rep < 4; rep++) begin
      rd  = nz_reg();
      rs1 = regno_t'($urandom);
      rs2 = regno_t'($urandom);
      i12 = 12'($urandom);
      b13 = {12'($urandom), 1'b0};
      u20 = 20'($urandom);
      j21 = {20'($urandom), 1'b0};
      issue_expect(enc_i(i12, rs1, 3'd0, rd, OPC_IMM), op_addi, sext(i12, 12), 5'b00001, rd);
      issue_expect(enc_i(i12, rs1, 3'd2, rd, OPC_LOAD), op_lw, sext(i12, 12), 5'b00101, rd);
      issue_expect(enc_s(i12, rs2, rs1), op_sw, sext(i12, 12), 5'b00010, i12[4:0]);
      issue_expect(enc_b(b13, rs2, rs1), op_beq, sext(b13, 13), 5'b10000,
                   {b13[4:1], b13[11]});
      issue_expect({u20, rd, OPC_LUI}, op_lui, {u20, 12'h000}, 5'b00001, rd);
      issue_expect(enc_j(j21, rd), op_jal, sext(j21, 21), 5'b01001, rd);
    end
  endtask

  task automatic test_reg_file();
    regno_t r;
    word_t  v;
    for (int n = 0; n < 8; n++) begin
      r = nz_reg();
      v = $urandom;
      step(1'b1, enc_i(12'h000, 5'd0, 3'd0, r, OPC_IMM), 1'b0, '0, '0);  // marks r busy
      // unissued read in the writeback cycle sees the new value
      step(1'b0, enc_r(7'h00, r, r, 3'd0, 5'd0, OPC_OP), 1'b1, r, v);
      model[r] = v;
      check_bit("stall", 1'b0, stall_seen);
      check_bit("de_valid", 1'b0, de_valid);
      check_word("de_rs1_val", v, de_rs1_val);
      check_word("de_rs2_val", v, de_rs2_val);
      step(1'b1, enc_r(7'h00, 5'd0, r, 3'd0, 5'd0, OPC_OP), 1'b0, '0, '0);
      check_bit("de_valid", 1'b1, de_valid);
      check_word("de_rs1_val", v, de_rs1_val);
      check_word("de_rs2_val", '0, de_rs2_val);
    end
    step(1'b0, '0, 1'b1, 5'd0, $urandom);  // x0 stays zero
    check_word("de_rs1_val", '0, de_rs1_val);
    step(1'b1, enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, OPC_OP), 1'b0, '0, '0);
    check_word("de_rs1_val", '0, de_rs1_val);
  endtask

  task automatic test_data_hazard();
    word_t v;
    word_t dep;
    v   = $urandom;
    dep = enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd0, OPC_OP);
    step(1'b1, enc_i(12'h000, 5'd0, 3'd0, 5'd5, OPC_IMM), 1'b0, '0, '0);
    for (int k = 0; k < 2; k++) begin
      step(1'b1, dep, 1'b0, '0, '0);
      check_bit("stall", 1'b1, stall_seen);
      check_bit("de_valid", 1'b0, de_valid);
    end
    step(1'b1, dep, 1'b1, 5'd5, v);  // still stalled through the writeback cycle
    model[5] = v;
    check_bit("stall", 1'b1, stall_seen);
    check_bit("de_valid", 1'b0, de_valid);
    step(1'b1, dep, 1'b0, '0, '0);
    check_bit("stall", 1'b0, stall_seen);
    check_bit("de_valid", 1'b1, de_valid);
    check_op("de_op", op_add, de_op);
    check_word("de_rs1_val", v, de_rs1_val);
    check_word("de_rs2_val", v, de_rs2_val);
  endtask

  task automatic test_mispredict_invalid();
    word_t bad;
    br_mispred = 1'b1;
    step(1'b1, enc_i(12'h001, 5'd0, 3'd0, 5'd9, OPC_IMM), 1'b0, '0, '0);
    br_mispred = 1'b0;
    check_bit("stall", 1'b1, stall_seen);
    check_bit("de_valid", 1'b0, de_valid);
    check_op("de_op", op_invalid, de_op);
    check_bit("de_wr_reg", 1'b0, de_wr_reg);
    // the squashed write left x9 free
    issue_expect(enc_r(7'h00, 5'd9, 5'd9, 3'd0, 5'd0, OPC_OP), op_add, '0, 5'b00000, 5'd0);
    bad = ($urandom & 32'hffff_ff80) | 32'h7f;
    issue_expect(bad, op_invalid, '0, 5'b00000, bad[11:7]);
    step(1'b1, enc_i(12'h000, 5'd0, 3'd0, 5'd12, OPC_IMM), 1'b0, '0, '0);
    step(1'b0, enc_r(7'h00, 5'd12, 5'd12, 3'd0, 5'd10, OPC_OP), 1'b0, '0, '0);
    check_bit("stall", 1'b0, stall_seen);
    issue_expect(enc_r(7'h00, 5'd10, 5'd10, 3'd0, 5'd0, OPC_OP), op_add, '0, 5'b00000, 5'd0);
    retire(5'd12);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    fe_valid   = 1'b0;
    fe_inst    = '0;
    fe_pc      = '0;
    fe_pcplus  = '0;
    fe_pcnext  = '0;
    br_mispred = 1'b0;
    wb_wr_reg  = 1'b0;
    wb_regno   = '0;
    wb_regval  = '0;
    reset      = 1'b1;
    errors     = 0;
    void'($urandom(25407));
    for (int k = 0; k < 32; k++)
      model[k] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_bit("de_valid", 1'b0, de_valid);
    check_bit("stall", 1'b0, stall);
    test_alu_decode();
    test_immediates();
    test_reg_file();
    test_data_hazard();
    test_mispredict_invalid();
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
    fail_run();
  end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock
module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);
  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;
endmodule

`default_nettype wire
